/* source/dec_pkg.sv */
`default_nettype none

package dec_pkg;

   //**************************************************************************
   // widths
   //**************************************************************************
   localparam int XLEN         = 64;    // register width
   localparam int REG_AW       = 5;     // register address bits
   localparam int NUM_REGS     = 32;    // entries per file
   localparam int INSN_W       = 32;    // one retired instruction
   localparam int CAUSE_W      = 5;     // exception cause
   localparam int TRACE_PORTS  = 3;     // i0, i1, interrupt
   localparam int TRACE_INSN_W = TRACE_PORTS * INSN_W;
   localparam int TRACE_ADDR_W = TRACE_PORTS * XLEN;

   // operand source file, acts as the operand opcode
   typedef enum logic {
      SRC_INT = 1'b0,                   // integer file
      SRC_FP  = 1'b1                    // float file
   } src_file_e;

   //**************************************************************************
   // port structs
   //**************************************************************************
   typedef struct packed {
      logic              wen;           // slot writes back
      logic              is_fp;         // target is float file
      logic [REG_AW-1:0] waddr;
      logic [XLEN-1:0]   wdata;
   } wb_req_t;

   typedef struct packed {
      logic              wen;           // load data returned
      logic [REG_AW-1:0] waddr;
      logic [XLEN-1:0]   wdata;
   } nbl_req_t;

   typedef struct packed {
      logic              wen;
      logic [REG_AW-1:0] waddr;
      logic [XLEN-1:0]   wdata;
   } rf_wr_t;

   typedef struct packed {
      logic              rden;          // low returns zero
      logic [REG_AW-1:0] raddr;
   } rf_rd_t;

   typedef struct packed {
      logic              rs1_en;
      logic              rs2_en;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      src_file_e         rs1_file;
      src_file_e         rs2_file;
   } src_req_t;

   typedef struct packed {
      logic               i0_valid;     // slot 0 retired
      logic               i1_valid;     // slot 1 retired
      logic               i0_exc;       // slot 0 took exception
      logic               i1_exc;
      logic               int_valid;    // interrupt taken
      logic [INSN_W-1:0]  i0_insn;
      logic [INSN_W-1:0]  i1_insn;
      logic [XLEN-1:0]    i0_pc;
      logic [XLEN-1:0]    i1_pc;
      logic [CAUSE_W-1:0] cause;
      logic [XLEN-1:0]    tval;
   } retire_t;

   typedef struct packed {
      logic [TRACE_INSN_W-1:0] insn;    // slot 0 low, then slot 1
      logic [TRACE_ADDR_W-1:0] address; // pc per slot, bit 0 zero
      logic [TRACE_PORTS-1:0]  valid;
      logic [TRACE_PORTS-1:0]  exception;
      logic [CAUSE_W-1:0]      ecause;
      logic [TRACE_PORTS-1:0]  interrupt;
      logic [XLEN-1:0]         tval;
   } trace_pkt_t;

endpackage

`default_nettype wire

/* source/dec_wb_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_wb_ctl #(
   parameter bit FP_EN = 1'b1                      // float file present
) (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  dec_pkg::wb_req_t        wb0_i,          // slot 0 writeback
   input  dec_pkg::wb_req_t        wb1_i,          // slot 1 writeback
   input  dec_pkg::nbl_req_t       nbl_i,          // non-blocking load return
   input  logic                    fp_dirty_clr_i, // clear sticky dirty
   output dec_pkg::rf_wr_t [2:0]   gpr_wr_o,       // 0 slot0, 1 slot1, 2 load
   output dec_pkg::rf_wr_t [1:0]   fpr_wr_o,       // 0 slot0, 1 slot1
   output logic                    fp_dirty_o
);

   dec_pkg::wb_req_t [1:0] wb;                     // slots indexed
   logic                   fp_wr_any;              // any float write this cycle
   logic                   fp_dirty_q;

   assign wb = {wb1_i, wb0_i};

   //**************************************************************************
   // writeback routing
   //**************************************************************************
   always_comb begin
      for (int s = 0; s < 2; s++) begin
         gpr_wr_o[s].wen   = wb[s].wen & ~wb[s].is_fp;          // integer result
         gpr_wr_o[s].waddr = wb[s].waddr;
         gpr_wr_o[s].wdata = wb[s].wdata;
         fpr_wr_o[s].wen   = wb[s].wen & wb[s].is_fp & FP_EN;   // dropped without fpu
         fpr_wr_o[s].waddr = wb[s].waddr;
         fpr_wr_o[s].wdata = wb[s].wdata;
      end
      // load return only ever targets the integer file
      gpr_wr_o[2].wen   = nbl_i.wen;
      gpr_wr_o[2].waddr = nbl_i.waddr;
      gpr_wr_o[2].wdata = nbl_i.wdata;
   end

   assign fp_wr_any = fpr_wr_o[0].wen | fpr_wr_o[1].wen;

   //**************************************************************************
   // sticky float state dirty
   //**************************************************************************
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fp_dirty_q <= 1'b0;
      end else if (fp_wr_any) begin
         fp_dirty_q <= 1'b1;                       // set beats clear
      end else if (fp_dirty_clr_i) begin
         fp_dirty_q <= 1'b0;
      end
   end

   assign fp_dirty_o = fp_dirty_q;

endmodule

`default_nettype wire

/* source/dec_gpr_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_gpr_ctl (
   input  logic                              clk,
   input  logic                              arst_n_i,
   input  dec_pkg::rf_wr_t [2:0]             wr_i,     // 0 slot0, 1 slot1, 2 load
   input  dec_pkg::rf_rd_t [3:0]             rd_i,     // i0 rs1/rs2, i1 rs1/rs2
   output logic [3:0][dec_pkg::XLEN-1:0]     rdata_o
);

   // x0 entry is reset and never written
   logic [dec_pkg::NUM_REGS-1:0][dec_pkg::XLEN-1:0] regs;

   //**************************************************************************
   // write ports, higher index wins on same address
   //**************************************************************************
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         regs <= '0;
      end else begin
         for (int p = 0; p < 3; p++) begin
            if (wr_i[p].wen && (wr_i[p].waddr != '0)) begin  // x0 hardwired
               regs[wr_i[p].waddr] <= wr_i[p].wdata;          // later port overrides
            end
         end
      end
   end

   // read ports, no bypass of same-cycle writes
   always_comb begin
      for (int p = 0; p < 4; p++) begin
         if (rd_i[p].rden) begin
            rdata_o[p] = regs[rd_i[p].raddr];   // entry 0 holds zero
         end else begin
            rdata_o[p] = '0;                    // idle port
         end
      end
   end

endmodule

`default_nettype wire

/* source/dec_fpr_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_fpr_ctl (
   input  logic                              clk,
   input  logic                              arst_n_i,
   input  dec_pkg::rf_wr_t [1:0]             wr_i,     // 0 slot0, 1 slot1
   input  dec_pkg::rf_rd_t [3:0]             rd_i,     // port 2 shared with rs3
   output logic [3:0][dec_pkg::XLEN-1:0]     rdata_o
);

   logic [dec_pkg::NUM_REGS-1:0][dec_pkg::XLEN-1:0] fregs;  // f0 is a normal entry

   // slot 1 written last so it wins a same-address collision
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fregs <= '0;
      end else begin
         for (int p = 0; p < 2; p++) begin
            if (wr_i[p].wen) begin
               fregs[wr_i[p].waddr] <= wr_i[p].wdata;
            end
         end
      end
   end

   always_comb begin
      for (int p = 0; p < 4; p++) begin
         if (rd_i[p].rden) begin
            rdata_o[p] = fregs[rd_i[p].raddr];  // old value on same-cycle write
         end else begin
            rdata_o[p] = '0;
         end
      end
   end

endmodule

`default_nettype wire

/* source/dec_operand_sel.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_operand_sel (
   input  dec_pkg::src_req_t                 src_i0_i,
   input  dec_pkg::src_req_t                 src_i1_i,
   input  logic                              rs3_en_i,      // fused op needs rs3
   input  logic [dec_pkg::REG_AW-1:0]        rs3_i,
   input  logic [dec_pkg::XLEN-1:0]          immed_i,
   output dec_pkg::rf_rd_t [3:0]             gpr_rd_o,
   output dec_pkg::rf_rd_t [3:0]             fpr_rd_o,
   input  logic [3:0][dec_pkg::XLEN-1:0]     gpr_rdata_i,
   input  logic [3:0][dec_pkg::XLEN-1:0]     fpr_rdata_i,
   output logic [dec_pkg::XLEN-1:0]          i0_rs1_o,
   output logic [dec_pkg::XLEN-1:0]          i0_rs2_o,
   output logic [dec_pkg::XLEN-1:0]          i1_rs1_o,
   output logic [dec_pkg::XLEN-1:0]          i1_rs2_o,
   output logic [dec_pkg::XLEN-1:0]          immed_or_rs3_o
);

   logic                              src_en   [4];   // per source, port order
   logic [dec_pkg::REG_AW-1:0]        src_addr [4];
   dec_pkg::src_file_e                src_file [4];
   logic [3:0][dec_pkg::XLEN-1:0]     operand;

   // flatten the two slots into port order
   always_comb begin
      src_en[0]   = src_i0_i.rs1_en;
      src_addr[0] = src_i0_i.rs1;
      src_file[0] = src_i0_i.rs1_file;
      src_en[1]   = src_i0_i.rs2_en;
      src_addr[1] = src_i0_i.rs2;
      src_file[1] = src_i0_i.rs2_file;
      src_en[2]   = src_i1_i.rs1_en;
      src_addr[2] = src_i1_i.rs1;
      src_file[2] = src_i1_i.rs1_file;
      src_en[3]   = src_i1_i.rs2_en;
      src_addr[3] = src_i1_i.rs2;
      src_file[3] = src_i1_i.rs2_file;
   end

   always_comb begin
      for (int p = 0; p < 4; p++) begin
         gpr_rd_o[p].rden  = src_en[p] && (src_file[p] == dec_pkg::SRC_INT);
         gpr_rd_o[p].raddr = src_addr[p];
         fpr_rd_o[p].rden  = src_en[p] && (src_file[p] == dec_pkg::SRC_FP);
         fpr_rd_o[p].raddr = src_addr[p];
         operand[p] = (src_file[p] == dec_pkg::SRC_FP) ? fpr_rdata_i[p] : gpr_rdata_i[p];
      end
      if (rs3_en_i) begin                       // rs3 takes float port 2
         fpr_rd_o[2].rden  = 1'b1;
         fpr_rd_o[2].raddr = rs3_i;
      end
   end

   assign i0_rs1_o       = operand[0];
   assign i0_rs2_o       = operand[1];
   assign i1_rs1_o       = operand[2];          // sees rs3 data when shared
   assign i1_rs2_o       = operand[3];
   assign immed_or_rs3_o = rs3_en_i ? fpr_rdata_i[2] : immed_i;

endmodule

`default_nettype wire

/* source/dec_trace_pack.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_trace_pack (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  dec_pkg::retire_t      retire_i,     // retire info, this cycle
   output dec_pkg::trace_pkt_t   trace_o       // same info one cycle later
);

   logic [dec_pkg::TRACE_PORTS-1:0]  valid_d;
   logic [dec_pkg::TRACE_PORTS-1:0]  exc_d;
   logic [dec_pkg::TRACE_PORTS-1:0]  int_d;
   logic [dec_pkg::TRACE_PORTS-1:0]  valid_q;
   logic [dec_pkg::TRACE_PORTS-1:0]  exc_q;
   logic [dec_pkg::TRACE_PORTS-1:0]  int_q;
   logic [dec_pkg::TRACE_INSN_W-1:0] insn_q;
   logic [dec_pkg::TRACE_ADDR_W-1:0] addr_q;
   logic [dec_pkg::CAUSE_W-1:0]      ecause_q;
   logic [dec_pkg::XLEN-1:0]         tval_q;

   //**************************************************************************
   // per-port flags, bit 2 is the interrupt port
   //**************************************************************************
   assign valid_d = {retire_i.int_valid,
                     retire_i.i1_valid | retire_i.i1_exc,   // slot 1 incl. exception
                     retire_i.i0_valid | retire_i.i0_exc};
   assign exc_d   = {retire_i.int_valid, retire_i.i1_exc, retire_i.i0_exc};
   assign int_d   = {retire_i.int_valid, 2'b00};             // only top port

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= '0;
         exc_q   <= '0;
         int_q   <= '0;
      end else begin
         valid_q <= valid_d;
         exc_q   <= exc_d;
         int_q   <= int_d;
      end
   end

   // payload, qualified by valid_q
   always_ff @(posedge clk) begin
      insn_q   <= {{dec_pkg::INSN_W{1'b0}}, retire_i.i1_insn, retire_i.i0_insn};
      addr_q   <= {{dec_pkg::XLEN{1'b0}},
                   retire_i.i1_pc[dec_pkg::XLEN-1:1], 1'b0,  // pc bit 0 forced low
                   retire_i.i0_pc[dec_pkg::XLEN-1:1], 1'b0};
      ecause_q <= retire_i.cause;
      tval_q   <= retire_i.tval;
   end

   assign trace_o = '{insn:      insn_q,
                      address:   addr_q,
                      valid:     valid_q,
                      exception: exc_q,
                      ecause:    ecause_q,
                      interrupt: int_q,
                      tval:      tval_q};

endmodule

`default_nettype wire

/* source/dec_regs_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_regs_top #(
   parameter bit FP_EN = 1'b1                       // build float file
) (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  dec_pkg::wb_req_t              wb0_i,          // slot 0 writeback
   input  dec_pkg::wb_req_t              wb1_i,          // slot 1 writeback
   input  dec_pkg::nbl_req_t             nbl_i,          // load return
   input  logic                          fp_dirty_clr_i,
   input  dec_pkg::src_req_t             src_i0_i,       // slot 0 sources
   input  dec_pkg::src_req_t             src_i1_i,       // slot 1 sources
   input  logic                          rs3_en_i,
   input  logic [dec_pkg::REG_AW-1:0]    rs3_i,
   input  logic [dec_pkg::XLEN-1:0]      immed_i,
   input  dec_pkg::retire_t              retire_i,
   output logic [dec_pkg::XLEN-1:0]      i0_rs1_o,
   output logic [dec_pkg::XLEN-1:0]      i0_rs2_o,
   output logic [dec_pkg::XLEN-1:0]      i1_rs1_o,
   output logic [dec_pkg::XLEN-1:0]      i1_rs2_o,
   output logic [dec_pkg::XLEN-1:0]      immed_or_rs3_o,
   output logic                          fp_dirty_o,
   output dec_pkg::trace_pkt_t           trace_o
);

   dec_pkg::rf_wr_t [2:0]             gpr_wr;      // 0 slot0, 1 slot1, 2 load
   dec_pkg::rf_wr_t [1:0]             fpr_wr;
   dec_pkg::rf_rd_t [3:0]             gpr_rd;
   dec_pkg::rf_rd_t [3:0]             fpr_rd;
   logic [3:0][dec_pkg::XLEN-1:0]     gpr_rdata;
   logic [3:0][dec_pkg::XLEN-1:0]     fpr_rdata;

   //**************************************************************************
   // write side
   //**************************************************************************
   dec_wb_ctl #(
      .FP_EN (FP_EN)
   ) wb_ctl (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .wb0_i          (wb0_i),
      .wb1_i          (wb1_i),
      .nbl_i          (nbl_i),
      .fp_dirty_clr_i (fp_dirty_clr_i),
      .gpr_wr_o       (gpr_wr),
      .fpr_wr_o       (fpr_wr),
      .fp_dirty_o     (fp_dirty_o)
   );

   //**************************************************************************
   // architectural register files
   //**************************************************************************
   dec_gpr_ctl arf (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .wr_i     (gpr_wr),
      .rd_i     (gpr_rd),
      .rdata_o  (gpr_rdata)
   );

   if (FP_EN) begin : g_fpr
      dec_fpr_ctl f_arf (
         .clk      (clk),
         .arst_n_i (arst_n_i),
         .wr_i     (fpr_wr),
         .rd_i     (fpr_rd),
         .rdata_o  (fpr_rdata)
      );
   end else begin : g_no_fpr
      assign fpr_rdata = '0;                        // no float file built
   end

   //**************************************************************************
   // read side and trace
   //**************************************************************************
   dec_operand_sel opsel (
      .src_i0_i       (src_i0_i),
      .src_i1_i       (src_i1_i),
      .rs3_en_i       (rs3_en_i),
      .rs3_i          (rs3_i),
      .immed_i        (immed_i),
      .gpr_rd_o       (gpr_rd),
      .fpr_rd_o       (fpr_rd),
      .gpr_rdata_i    (gpr_rdata),
      .fpr_rdata_i    (fpr_rdata),
      .i0_rs1_o       (i0_rs1_o),
      .i0_rs2_o       (i0_rs2_o),
      .i1_rs1_o       (i1_rs1_o),
      .i1_rs2_o       (i1_rs2_o),
      .immed_or_rs3_o (immed_or_rs3_o)
   );

   dec_trace_pack trace (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .retire_i (retire_i),
      .trace_o  (trace_o)
   );

endmodule

`default_nettype wire

/* sim/dec_regs_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_regs_assertions (
   input  logic                        clk,
   input  logic                        arst_n_i,
   input  logic                        fp_dirty_clr_i,
   input  logic                        rs3_en_i,
   input  logic [dec_pkg::XLEN-1:0]    immed_i,
   input  logic [dec_pkg::XLEN-1:0]    immed_or_rs3_o,
   input  logic                        fp_dirty_o,
   input  dec_pkg::trace_pkt_t         trace_o
);

   //**************************************************************************
   // sticky dirty flag
   //**************************************************************************
   dirty_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
      fp_dirty_o && !fp_dirty_clr_i |=> fp_dirty_o)
      else $error("float dirty flag dropped without a clear");

   // first edge out of reset
   trace_idle_after_reset: assert property (@(posedge clk)
      $rose(arst_n_i) |-> trace_o.valid == '0)
      else $error("trace valid set right after reset release");

   immed_pass: assert property (@(posedge clk) disable iff (!arst_n_i)
      !rs3_en_i |-> immed_or_rs3_o == immed_i)   // no rs3, plain immediate
      else $error("immediate output differs from immediate input");

endmodule

bind dec_regs_top dec_regs_assertions checks (
   .clk            (clk),
   .arst_n_i       (arst_n_i),
   .fp_dirty_clr_i (fp_dirty_clr_i),
   .rs3_en_i       (rs3_en_i),
   .immed_i        (immed_i),
   .immed_or_rs3_o (immed_or_rs3_o),
   .fp_dirty_o     (fp_dirty_o),
   .trace_o        (trace_o)
);

`default_nettype wire

/* sim/dec_regs_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dec_regs_tb;

   localparam int RST_CYC = 10;
   localparam int P1_CYC  = 60;                    // integer traffic
   localparam int P2_CYC  = 40;                    // float routing
   localparam int P3_CYC  = 3;                     // same-address collisions
   localparam int P4_CYC  = 30;                    // rs3 sharing
   localparam int P5_CYC  = 8;                     // dirty flag sequence
   localparam int P6_CYC  = 41;                    // trace with a last idle cycle
   localparam int TIMEOUT_CYC = RST_CYC + P1_CYC + P2_CYC + P3_CYC + P4_CYC
                                + P5_CYC + P6_CYC + 50;

   logic clk;
   logic arst_n;
   dec_pkg::wb_req_t    wb0, wb1;
   dec_pkg::nbl_req_t   nbl;
   logic                fp_dirty_clr;
   dec_pkg::src_req_t   src_i0, src_i1;
   logic                rs3_en;
   logic [dec_pkg::REG_AW-1:0] rs3;
   logic [dec_pkg::XLEN-1:0]   immed;
   dec_pkg::retire_t    retire;
   logic [dec_pkg::XLEN-1:0]   i0_rs1, i0_rs2, i1_rs1, i1_rs2, immed_or_rs3;
   logic                fp_dirty;
   dec_pkg::trace_pkt_t trace;

   logic [dec_pkg::XLEN-1:0] m_gpr [dec_pkg::NUM_REGS];  // shadow integer file
   logic [dec_pkg::XLEN-1:0] m_fpr [dec_pkg::NUM_REGS];  // shadow float file
   logic                m_dirty;
   dec_pkg::trace_pkt_t exp_trace;                 // due on trace_o next cycle
   logic [31:0]         lcg_state;
   int                  word_errs, bit_errs, trace_errs;
   int                  cycle_cnt;

   dec_regs_top #(.FP_EN(1'b1)) dut (
      .clk(clk), .arst_n_i(arst_n), .wb0_i(wb0), .wb1_i(wb1), .nbl_i(nbl),
      .fp_dirty_clr_i(fp_dirty_clr), .src_i0_i(src_i0), .src_i1_i(src_i1),
      .rs3_en_i(rs3_en), .rs3_i(rs3), .immed_i(immed), .retire_i(retire),
      .i0_rs1_o(i0_rs1), .i0_rs2_o(i0_rs2), .i1_rs1_o(i1_rs1), .i1_rs2_o(i1_rs2),
      .immed_or_rs3_o(immed_or_rs3), .fp_dirty_o(fp_dirty), .trace_o(trace)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                      // 100 ns period
   end

   //**************************************************************************
   // random sources
   //**************************************************************************
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [dec_pkg::XLEN-1:0] rand_word();
      return {next_rand(), next_rand()};
   endfunction

   function automatic dec_pkg::wb_req_t rand_wb(logic fp_mix);
      dec_pkg::wb_req_t w;
      logic [31:0]      r;
      r       = next_rand();
      w.wen   = r[0] | r[1];                       // mostly writing
      w.is_fp = fp_mix & r[2];
      w.waddr = r[8:4];
      w.wdata = rand_word();
      return w;
   endfunction

   function automatic dec_pkg::nbl_req_t rand_nbl();
      dec_pkg::nbl_req_t n;
      logic [31:0]       r;
      r       = next_rand();
      n.wen   = r[0];
      n.waddr = r[5:1];
      n.wdata = rand_word();
      return n;
   endfunction

   function automatic dec_pkg::src_req_t rand_src(logic fp_mix);
      dec_pkg::src_req_t s;
      logic [31:0]       r;
      r          = next_rand();
      s.rs1_en   = r[0] | r[1];                    // enable low now and then
      s.rs2_en   = r[2] | r[3];
      s.rs1      = r[8:4];
      s.rs2      = r[13:9];
      s.rs1_file = fp_mix ? dec_pkg::src_file_e'(r[14]) : dec_pkg::SRC_INT;
      s.rs2_file = fp_mix ? dec_pkg::src_file_e'(r[15]) : dec_pkg::SRC_INT;
      return s;
   endfunction

   function automatic dec_pkg::retire_t rand_retire();
      dec_pkg::retire_t t;
      logic [31:0]      r;
      r           = next_rand();
      t.i0_valid  = r[0];
      t.i1_valid  = r[1];
      t.i0_exc    = r[2] & r[3];
      t.i1_exc    = r[4] & r[5];
      t.int_valid = r[6] & r[7];
      t.cause     = r[12:8];
      t.i0_insn   = next_rand();
      t.i1_insn   = next_rand();
      t.i0_pc     = rand_word();
      t.i1_pc     = rand_word();
      t.tval      = rand_word();
      return t;
   endfunction

   //**************************************************************************
   // reference model
   //**************************************************************************
   function automatic logic [dec_pkg::XLEN-1:0] model_read(logic en,
         logic [dec_pkg::REG_AW-1:0] addr, dec_pkg::src_file_e file);
      if (!en) return '0;                          // idle port
      if (file == dec_pkg::SRC_FP) return m_fpr[addr];
      if (addr == '0) return '0;                   // x0
      return m_gpr[addr];
   endfunction

   function automatic dec_pkg::trace_pkt_t model_trace(dec_pkg::retire_t r);
      dec_pkg::trace_pkt_t t;
      t                 = '0;                      // third slot stays zero
      t.insn[31:0]      = r.i0_insn;
      t.insn[63:32]     = r.i1_insn;
      t.address[63:0]   = r.i0_pc & ~64'd1;        // halfword aligned pc
      t.address[127:64] = r.i1_pc & ~64'd1;
      t.valid[0]        = r.i0_valid || r.i0_exc;
      t.valid[1]        = r.i1_valid || r.i1_exc;
      t.valid[2]        = r.int_valid;
      t.exception[0]    = r.i0_exc;
      t.exception[1]    = r.i1_exc;
      t.exception[2]    = r.int_valid;
      t.interrupt[2]    = r.int_valid;
      t.ecause          = r.cause;
      t.tval            = r.tval;
      return t;
   endfunction

   // later writes override earlier ones at the edge
   task automatic update_model();
      logic fp_wr;
      fp_wr = 1'b0;
      if (wb0.wen && !wb0.is_fp && wb0.waddr != '0) m_gpr[wb0.waddr] = wb0.wdata;
      if (wb1.wen && !wb1.is_fp && wb1.waddr != '0) m_gpr[wb1.waddr] = wb1.wdata;
      if (nbl.wen && nbl.waddr != '0) m_gpr[nbl.waddr] = nbl.wdata;
      if (wb0.wen && wb0.is_fp) begin
         m_fpr[wb0.waddr] = wb0.wdata;
         fp_wr = 1'b1;
      end
      if (wb1.wen && wb1.is_fp) begin
         m_fpr[wb1.waddr] = wb1.wdata;
         fp_wr = 1'b1;
      end
      if (fp_wr) m_dirty = 1'b1;                   // set beats clear
      else if (fp_dirty_clr) m_dirty = 1'b0;
      exp_trace = model_trace(retire);
   endtask

   //**************************************************************************
   // compare tasks
   //**************************************************************************
   task automatic check_word(string name, logic [dec_pkg::XLEN-1:0] exp,
                             logic [dec_pkg::XLEN-1:0] act);
      if (act !== exp) begin
         word_errs++;
         $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         bit_errs++;
         $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_trace(dec_pkg::trace_pkt_t exp, dec_pkg::trace_pkt_t act);
      if (act !== exp) begin
         trace_errs++;
         $display("Fail trace_o expected %h actual %h at %0t", exp, act, $time);
      end
   endtask

   task automatic check_outputs();
      logic [dec_pkg::XLEN-1:0] exp_i1_rs1;
      logic [dec_pkg::XLEN-1:0] exp_imm;
      exp_i1_rs1 = model_read(src_i1.rs1_en, src_i1.rs1, src_i1.rs1_file);
      if (rs3_en && src_i1.rs1_file == dec_pkg::SRC_FP) exp_i1_rs1 = m_fpr[rs3];
      exp_imm = rs3_en ? m_fpr[rs3] : immed;       // port 2 serves rs3
      check_word("i0_rs1_o", model_read(src_i0.rs1_en, src_i0.rs1, src_i0.rs1_file),
                 i0_rs1);
      check_word("i0_rs2_o", model_read(src_i0.rs2_en, src_i0.rs2, src_i0.rs2_file),
                 i0_rs2);
      check_word("i1_rs1_o", exp_i1_rs1, i1_rs1);
      check_word("i1_rs2_o", model_read(src_i1.rs2_en, src_i1.rs2, src_i1.rs2_file),
                 i1_rs2);
      check_word("immed_or_rs3_o", exp_imm, immed_or_rs3);
      check_bit("fp_dirty_o", m_dirty, fp_dirty);
      check_trace(exp_trace, trace);
   endtask

   task automatic clear_inputs();
      wb0 = '0;
      wb1 = '0;
      nbl = '0;
      fp_dirty_clr = 1'b0;
      src_i0 = '0;
      src_i1 = '0;
      rs3_en = 1'b0;
      rs3 = '0;
      immed = '0;
      retire = '0;
   endtask

   // entered and left 10 ns after an edge
   task automatic run_cycle();
      #70;                                         // settled before the edge
      check_outputs();
      @(posedge clk);
      update_model();
      #10;
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("Error: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("Test failures found");
         $finish;
      end
   end

   //**************************************************************************
   // stimulus
   //**************************************************************************
   initial begin
      logic [31:0] r;
      logic [dec_pkg::REG_AW-1:0] a;
      lcg_state = 32'd28;
      cycle_cnt = 0;
      word_errs = 0;
      bit_errs = 0;
      trace_errs = 0;
      clear_inputs();
      arst_n = 1'b0;
      for (int i = 0; i < dec_pkg::NUM_REGS; i++) begin
         m_gpr[i] = '0;
         m_fpr[i] = '0;
      end
      m_dirty = 1'b0;
      exp_trace = '0;                              // payload flops load zero in reset
      repeat (RST_CYC) @(posedge clk);
      #10;
      arst_n = 1'b1;

      for (int i = 0; i < P1_CYC; i++) begin       // integer only
         clear_inputs();
         wb0 = rand_wb(1'b0);
         wb1 = rand_wb(1'b0);
         nbl = rand_nbl();
         src_i0 = rand_src(1'b0);
         src_i1 = rand_src(1'b0);
         run_cycle();
      end

      for (int i = 0; i < P2_CYC; i++) begin       // float and integer mixed
         clear_inputs();
         wb0 = rand_wb(1'b1);
         wb1 = rand_wb(1'b1);
         src_i0 = rand_src(1'b1);
         src_i0.rs1_en = 1'b1;
         src_i0.rs2_en = 1'b1;
         src_i0.rs2 = src_i0.rs1;                  // same address in both files
         src_i0.rs1_file = dec_pkg::SRC_FP;
         src_i0.rs2_file = dec_pkg::SRC_INT;
         src_i1 = rand_src(1'b1);
         run_cycle();
      end

      r = next_rand();
      a = r[4:0];
      if (a == '0) a = 5'd17;
      clear_inputs();                              // three integer writers on one address
      wb0 = '{wen: 1'b1, is_fp: 1'b0, waddr: a, wdata: rand_word()};
      wb1 = '{wen: 1'b1, is_fp: 1'b0, waddr: a, wdata: rand_word()};
      nbl = '{wen: 1'b1, waddr: a, wdata: rand_word()};
      run_cycle();
      clear_inputs();                              // two float writers
      wb0 = '{wen: 1'b1, is_fp: 1'b1, waddr: a, wdata: rand_word()};
      wb1 = '{wen: 1'b1, is_fp: 1'b1, waddr: a, wdata: rand_word()};
      run_cycle();
      clear_inputs();
      src_i0 = '{rs1_en: 1'b1, rs2_en: 1'b1, rs1: a, rs2: a,
                 rs1_file: dec_pkg::SRC_INT, rs2_file: dec_pkg::SRC_FP};
      run_cycle();

      for (int i = 0; i < P4_CYC; i++) begin       // fused ops
         clear_inputs();
         r = next_rand();
         wb0 = rand_wb(1'b1);
         wb1 = rand_wb(1'b1);
         src_i0 = rand_src(1'b1);
         src_i1 = rand_src(1'b1);
         if (r[0]) src_i1.rs1_file = dec_pkg::SRC_FP;
         rs3_en = r[1] | r[2];
         rs3 = r[9:5];
         immed = rand_word();
         run_cycle();
      end

      for (int i = 0; i < P5_CYC; i++) begin
         clear_inputs();
         case (i)
            0: fp_dirty_clr = 1'b1;
            1, 3: begin                            // integer only
               wb0 = rand_wb(1'b0);
               wb0.wen = 1'b1;
            end
            2: begin
               wb1 = rand_wb(1'b1);
               wb1.wen = 1'b1;
               wb1.is_fp = 1'b1;
            end
            5: begin                               // clear and set together
               fp_dirty_clr = 1'b1;
               wb0 = rand_wb(1'b1);
               wb0.wen = 1'b1;
               wb0.is_fp = 1'b1;
            end
            6: fp_dirty_clr = 1'b1;
            default: ;
         endcase
         run_cycle();
      end

      for (int i = 0; i < P6_CYC; i++) begin
         clear_inputs();
         if (i < P6_CYC - 1) retire = rand_retire();  // last cycle only checks
         src_i0 = rand_src(1'b1);
         run_cycle();
      end

      $display("errors: operand %0d, dirty flag %0d, trace %0d",
               word_errs, bit_errs, trace_errs);
      if (word_errs + bit_errs + trace_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
source/dec_pkg.sv
source/dec_wb_ctl.sv
source/dec_gpr_ctl.sv
source/dec_fpr_ctl.sv
source/dec_operand_sel.sv
source/dec_trace_pack.sv
source/dec_regs_top.sv
sim/dec_regs_assertions.sv
sim/dec_regs_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module dec_regs_tb \
   -o dec_regs_sim &&
./obj_dir/dec_regs_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }
